// ==== Makefile ====
TOP  := tb_load_cache_top
SRCS := $(filter-out +%,$(shell cat load_cache_top.f))

all: run

# rebuilt only when a source, the header or the file list changes
obj_dir/V$(TOP): load_cache_top.f cache_config.svh $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f load_cache_top.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define CACHE_SETS       4
`define CACHE_LINE_WORDS 4

// bus widths
`define CACHE_ADDR_W     32
`define CACHE_DATA_W     32

`endif

// ==== cache_ifs.sv ====
// line fill request between lookup stage and refill engine
interface fill_if;
    import cache_pkg::*;

    logic  fill_req;
    set_t  fill_set;
    tag_t  fill_tag;
    logic  fill_done;
    line_t fill_line;

    modport lookup (
        output fill_req, fill_set, fill_tag,
        input  fill_done, fill_line
    );

    modport refill (
        input  fill_req, fill_set, fill_tag,
        output fill_done, fill_line
    );
endinterface

// lookup stage to format stage, valid/ready
interface lookup_if;
    import cache_pkg::*;

    logic  valid;
    logic  ready;
    word_t word;
    lane_t lane;
    logic  byte_load;
    logic  hit;

    modport source (
        output valid, word, lane, byte_load, hit,
        input  ready
    );

    modport sink (
        input  valid, word, lane, byte_load, hit,
        output ready
    );
endinterface

// ==== cache_lookup.sv ====
`include "cache_config.svh"

module cache_lookup (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             req_valid,
    input  cache_pkg::addr_t req_addr,
    input  logic             req_byte,
    output logic             req_ready,
    fill_if.lookup           fill,
    lookup_if.source         out
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMP,
        ST_FILL,
        ST_OUT
    } state_t;

    state_t                  state_q;
    logic [`CACHE_SETS-1:0]  valid_q;
    logic                    fill_req_q;
    logic                    missed_q;

    addr_t                   req_addr_q;
    logic                    req_byte_q;
    word_t                   word_q;
    logic                    hit_q;
    tag_t                    tag_q [`CACHE_SETS];
    line_t                   data_q [`CACHE_SETS];

    tag_t                    cur_tag;
    set_t                    cur_set;
    offset_t                 cur_offset;
    logic                    cur_hit;
    logic                    accept;

    assign cur_tag    = req_addr_q[`CACHE_ADDR_W-1 -: TAG_W];
    assign cur_set    = req_addr_q[LANE_W+OFFSET_W +: SET_W];
    assign cur_offset = req_addr_q[LANE_W +: OFFSET_W];
    assign cur_hit    = valid_q[cur_set] && (tag_q[cur_set] == cur_tag);

    // stage empty, or its item leaves this edge
    assign req_ready = (state_q == ST_IDLE) || (out.valid && out.ready);
    assign accept    = req_valid && req_ready;

    assign out.valid     = (state_q == ST_OUT);
    assign out.word      = word_q;
    assign out.lane      = req_addr_q[LANE_W-1:0];
    assign out.byte_load = req_byte_q;
    assign out.hit       = hit_q;

    // set and tag hold with the request while the fill runs
    assign fill.fill_req = fill_req_q;
    assign fill.fill_set = cur_set;
    assign fill.fill_tag = cur_tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_IDLE;
            valid_q    <= '0;
            fill_req_q <= 1'b0;
            missed_q   <= 1'b0;
        end else begin
            if (accept) begin
                missed_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_CMP;
                    end
                end
                ST_CMP: begin
                    if (cur_hit) begin
                        state_q <= ST_OUT;
                    end else begin
                        state_q    <= ST_FILL;
                        fill_req_q <= 1'b1;
                        missed_q   <= 1'b1;
                    end
                end
                ST_FILL: begin
                    // line lands now, compare again next cycle
                    if (fill.fill_done) begin
                        fill_req_q       <= 1'b0;
                        valid_q[cur_set] <= 1'b1;
                        state_q          <= ST_CMP;
                    end
                end
                default: begin
                    if (out.ready) begin
                        state_q <= accept ? ST_CMP : ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= req_addr;
            req_byte_q <= req_byte;
        end
        if (state_q == ST_CMP) begin
            word_q <= data_q[cur_set][cur_offset];
            hit_q  <= ~missed_q;
        end
        if (state_q == ST_FILL && fill.fill_done) begin
            tag_q[cur_set]  <= cur_tag;
            data_q[cur_set] <= fill.fill_line;
        end
    end

    a_no_fill_while_valid: assert property (@(posedge clk) disable iff (!arst_n)
        fill.fill_req |-> !out.valid);

    // a line just refilled is always reported as a miss
    a_hit_not_after_fill: assert property (@(posedge clk) disable iff (!arst_n)
        out.valid && out.hit |-> !fill.fill_req && !$past(fill.fill_req, 2));

endmodule

// ==== cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

    // address split: tag | set | word offset | byte lane
    localparam int LANE_W   = $clog2(`CACHE_DATA_W / 8);
    localparam int OFFSET_W = $clog2(`CACHE_LINE_WORDS);
    localparam int SET_W    = $clog2(`CACHE_SETS);
    localparam int TAG_W    = `CACHE_ADDR_W - SET_W - OFFSET_W - LANE_W;

    typedef logic [`CACHE_DATA_W-1:0] word_t;
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [SET_W-1:0]    set_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [LANE_W-1:0]   lane_t;

    // one cache line, word 0 at the lowest address
    typedef word_t line_t [`CACHE_LINE_WORDS];

endpackage

// ==== line_refill.sv ====
module line_refill (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ar_ready,
    input  logic             r_valid,
    input  cache_pkg::word_t r_data,
    output cache_pkg::addr_t ar_addr,
    output logic             ar_valid,
    output logic             r_ready,
    fill_if.refill           fill
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_AR,
        RF_R,
        RF_DONE
    } rf_state_t;

    rf_state_t state_q;
    offset_t   cnt_q;
    line_t     buf_q;

    // word address walks up from the line base
    assign ar_addr  = {fill.fill_tag, fill.fill_set, cnt_q, {LANE_W{1'b0}}};
    assign ar_valid = (state_q == RF_AR);
    assign r_ready  = (state_q == RF_R);

    assign fill.fill_done = (state_q == RF_DONE);
    assign fill.fill_line = buf_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= RF_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    if (fill.fill_req) begin
                        cnt_q   <= '0;
                        state_q <= RF_AR;
                    end
                end
                RF_AR: begin
                    if (ar_ready) begin
                        state_q <= RF_R;
                    end
                end
                RF_R: begin
                    // one read outstanding at a time
                    if (r_valid) begin
                        if (cnt_q == '1) begin
                            state_q <= RF_DONE;
                        end else begin
                            cnt_q   <= cnt_q + 1'b1;
                            state_q <= RF_AR;
                        end
                    end
                end
                default: begin
                    state_q <= RF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == RF_R && r_valid) begin
            buf_q[cnt_q] <= r_data;
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

    a_done_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        fill.fill_done |-> fill.fill_req);

endmodule

// ==== load_cache_top.f ====
+incdir+.
cache_pkg.sv
cache_ifs.sv
cache_lookup.sv
line_refill.sv
load_format.sv
load_cache_top.sv
tb_load_cache_top.sv

// ==== load_cache_top.sv ====
module load_cache_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             req_valid,
    input  cache_pkg::addr_t req_addr,
    input  logic             req_byte,
    output logic             req_ready,
    output logic             rsp_valid,
    output cache_pkg::word_t rsp_data,
    output logic             rsp_hit,
    input  logic             rsp_ready,
    output cache_pkg::addr_t ar_addr,
    output logic             ar_valid,
    input  logic             ar_ready,
    input  cache_pkg::word_t r_data,
    input  logic             r_valid,
    output logic             r_ready
);

    fill_if   fill0 ();
    lookup_if look0 ();

    cache_lookup u_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_byte  (req_byte),
        .req_ready (req_ready),
        .fill      (fill0.lookup),
        .out       (look0.source)
    );

    // refill engine hangs off the lookup stage
    line_refill u_refill (
        .clk      (clk),
        .arst_n   (arst_n),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .ar_addr  (ar_addr),
        .ar_valid (ar_valid),
        .r_ready  (r_ready),
        .fill     (fill0.refill)
    );

    load_format u_format (
        .clk       (clk),
        .arst_n    (arst_n),
        .rsp_ready (rsp_ready),
        .in        (look0.sink),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_hit   (rsp_hit)
    );

endmodule

// ==== load_format.sv ====
module load_format (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             rsp_ready,
    lookup_if.sink           in,
    output logic             rsp_valid,
    output cache_pkg::word_t rsp_data,
    output logic             rsp_hit
);
    import cache_pkg::*;

    word_t result;
    logic  take;

    // byte loads return the addressed lane zero-extended
    always_comb begin
        if (in.byte_load) begin
            result = word_t'(in.word[{in.lane, 3'b000} +: 8]);
        end else begin
            result = in.word;
        end
    end

    assign in.ready = !rsp_valid || rsp_ready;
    assign take     = in.valid && in.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp_data <= result;
            rsp_hit  <= in.hit;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

// ==== tb_load_cache_top.sv ====
module tb_load_cache_top;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int TIMEOUT  = 400;
    localparam int N_RANDOM = 200;

    logic  clk;
    logic  arst_n;
    logic  req_valid;
    addr_t req_addr;
    logic  req_byte;
    logic  req_ready;
    logic  rsp_valid;
    word_t rsp_data;
    logic  rsp_hit;
    logic  rsp_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  ar_ready;
    word_t r_data;
    logic  r_valid;
    logic  r_ready;

    // shadow of the cache directory, per set
    logic  sh_valid [4];
    tag_t  sh_tag [4];
    word_t exp_data [$];
    logic  exp_hit [$];
    addr_t ar_log [$];
    int    rsp_count;
    int    n_issued;
    logic  bp_en;

    load_cache_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t ref_mem_word(addr_t addr);
        logic [31:0] wa;
        wa = {2'b00, addr[31:2]};
        return (wa * 32'h9e37_79b1) ^ {wa[15:0], wa[31:16]} ^ 32'h0f0f_5a5a;
    endfunction

    function automatic word_t ref_load(addr_t addr, logic byte_ld);
        word_t w;
        w = ref_mem_word(addr);
        if (byte_ld) begin
            w = (w >> (8 * addr[1:0])) & 32'h0000_00ff;
        end
        return w;
    endfunction

    // direct mapped: the set simply takes the new tag
    function automatic logic shadow_lookup(addr_t addr);
        set_t s;
        tag_t t;
        logic hit;
        s = addr[5:4];
        t = addr[31:6];
        hit = sh_valid[s] && (sh_tag[s] == t);
        sh_valid[s] = 1'b1;
        sh_tag[s] = t;
        return hit;
    endfunction

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error %s: expected 0x%08h, got 0x%08h", name, exp, got));
        end
    endtask

    task automatic check_hit(string name, logic exp, logic got);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic got);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error %s: expected 0x%08h, got 0x%08h", name, exp, got));
        end
    endtask

    task automatic check_count(string name, int exp, int got);
        if (got != exp) begin
            stop_on_error($sformatf("** Error %s: expected 0x%0h, got 0x%0h", name, exp, got));
        end
    endtask

    // AXI4-Lite read slave, 0 to 3 idle cycles before each data beat
    initial begin : mem_model
        addr_t rd_addr;
        int    delay;
        logic  busy;
        logic  ar_hs;
        logic  r_hs;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        rd_addr  = '0;
        delay    = 0;
        busy     = 1'b0;
        ar_hs    = 1'b0;
        r_hs     = 1'b0;
        forever begin
            @(negedge clk);
            if (ar_hs) begin
                ar_ready = 1'b0;
                busy     = 1'b1;
                delay    = $urandom_range(3, 0);
            end
            if (r_hs) begin
                r_valid = 1'b0;
                busy    = 1'b0;
            end
            if (busy && !r_valid) begin
                if (delay == 0) begin
                    r_valid = 1'b1;
                    r_data  = ref_mem_word(rd_addr);
                end else begin
                    delay--;
                end
            end
            if (!busy && !ar_ready && ar_valid) begin
                ar_ready = 1'b1;
            end
            // handshakes that the coming rising edge completes
            ar_hs = ar_valid && ar_ready;
            r_hs  = r_valid && r_ready;
            if (ar_hs) begin
                rd_addr = ar_addr;
                ar_log.push_back(ar_addr);
            end
        end
    end

    initial begin : compare
        word_t d;
        logic  h;
        rsp_ready = 1'b0;
        rsp_count = 0;
        forever begin
            @(negedge clk);
            rsp_ready = bp_en ? ($urandom_range(3, 0) != 0) : 1'b1;
            if (rsp_valid && rsp_ready) begin
                if (exp_data.size() == 0) begin
                    stop_on_error("a response arrived with no load outstanding");
                end else begin
                    d = exp_data.pop_front();
                    h = exp_hit.pop_front();
                    check_word("rsp_data", d, rsp_data);
                    check_hit("rsp_hit", h, rsp_hit);
                    rsp_count++;
                end
            end
        end
    end

    // returns once the request is accepted at the next rising edge
    task automatic issue_load(addr_t addr, logic byte_ld, output logic hit);
        int waited;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        req_byte  = byte_ld;
        #1;
        waited = 0;
        while (!req_ready) begin
            if (waited == TIMEOUT) begin
                stop_on_error("a load request was never accepted");
            end else begin
                waited++;
                @(negedge clk);
                #1;
            end
        end
        hit = shadow_lookup(addr);
        exp_data.push_back(ref_load(addr, byte_ld));
        exp_hit.push_back(hit);
        n_issued++;
    endtask

    task automatic release_req();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_responses(int target);
        int waited;
        waited = 0;
        while (rsp_count < target) begin
            if (waited == TIMEOUT) begin
                stop_on_error("a load response did not arrive in time");
            end else begin
                waited++;
                @(negedge clk);
                #1;
            end
        end
    endtask

    // one load at a time, with the AR traffic it caused
    task automatic directed_load(addr_t addr, logic byte_ld);
        logic  hit;
        int    n0;
        addr_t base;
        n0 = ar_log.size();
        issue_load(addr, byte_ld, hit);
        release_req();
        wait_responses(n_issued);
        base = {addr[31:4], 4'h0};
        if (hit) begin
            check_count("AR handshakes on a hit", 0, ar_log.size() - n0);
        end else begin
            check_count("AR handshakes on a miss", 4, ar_log.size() - n0);
            for (int i = 0; i < 4; i++) begin
                check_addr("ar_addr", base + addr_t'(4 * i), ar_log[n0 + i]);
            end
        end
    endtask

    initial begin
        addr_t a;
        logic  hit;
        logic  byte_ld;
        void'($urandom(32'h3f6a152b));
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_byte  = 1'b0;
        bp_en     = 1'b0;
        n_issued  = 0;
        for (int s = 0; s < 4; s++) begin
            sh_valid[s] = 1'b0;
            sh_tag[s]   = '0;
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        #1;
        check_bit("req_ready", 1'b1, req_ready);
        check_bit("rsp_valid", 1'b0, rsp_valid);
        check_bit("ar_valid", 1'b0, ar_valid);

        // cold miss, then all four words of the line
        directed_load(32'h0000_1230, 1'b0);
        for (int w = 0; w < 4; w++) begin
            directed_load(32'h0000_1230 + addr_t'(4 * w), 1'b0);
        end
        for (int lane = 0; lane < 4; lane++) begin
            directed_load(32'h0000_1234 + addr_t'(lane), 1'b1);
        end

        // same set, other tag evicts the line
        directed_load(32'h0000_5670, 1'b0);
        directed_load(32'h0000_1238, 1'b0);
        directed_load(32'h0000_5674, 1'b1);

        // few tags so the sets see both hits and conflicts
        bp_en = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            byte_ld = 1'($urandom_range(1, 0));
            a = $urandom;
            a[31:6] = 26'h100 + 26'($urandom_range(2, 0));
            if (!byte_ld) begin
                a[1:0] = 2'b00;
            end
            issue_load(a, byte_ld, hit);
            if ($urandom_range(3, 0) == 0) begin
                release_req();
            end
        end
        release_req();
        wait_responses(n_issued);
        // last response leaves at the coming edge, both stages then empty
        @(negedge clk);
        #1;
        check_bit("rsp_valid", 1'b0, rsp_valid);
        check_bit("req_ready", 1'b1, req_ready);
        $display(">>> PASS");
        $finish;
    end

endmodule
